//--- verilog/lsu_pkg.sv
package lsu_pkg;

    // data and address width
    localparam int xlen = 32;

    // one strobe bit per byte lane
    localparam int mask_w = xlen / 8;

    // sram geometry, word index from address bits 9 to 2
    localparam int mem_words = 256;
    localparam int mem_aw = 8;

    // extra response latency, 0 to 7 cycles
    localparam int delay_w = 3;

    // master side
    typedef enum logic [2:0] {
        ls_idle,
        ls_rd_addr,
        ls_rd_data,
        ls_wr_req,
        ls_wr_resp
    } lsu_state_e;

    // slave side
    // ms_wr_data covers an aw that arrives ahead of its w
    typedef enum logic [2:0] {
        ms_idle,
        ms_rd_wait,
        ms_rd_resp,
        ms_wr_data,
        ms_wr_wait,
        ms_wr_resp
    } mem_state_e;

endpackage

//--- verilog/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if;

    // read address
    logic [lsu_pkg::xlen-1:0]   araddr;
    logic                       arvalid;
    logic                       arready;

    // read data
    logic [lsu_pkg::xlen-1:0]   rdata;
    logic                       rvalid;
    logic                       rready;

    // write address
    logic [lsu_pkg::xlen-1:0]   awaddr;
    logic                       awvalid;
    logic                       awready;

    // write data
    logic [lsu_pkg::xlen-1:0]   wdata;
    logic [lsu_pkg::mask_w-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;

    // write response, no resp code
    logic                       bvalid;
    logic                       bready;

    modport master (
        output araddr, arvalid, rready,
        output awaddr, awvalid,
        output wdata, wstrb, wvalid,
        output bready,
        input  arready, rdata, rvalid,
        input  awready, wready, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        input  awaddr, awvalid,
        input  wdata, wstrb, wvalid,
        input  bready,
        output arready, rdata, rvalid,
        output awready, wready, bvalid
    );

endinterface

//--- verilog/lsu_align.sv
`timescale 1ns/1ps

module lsu_align (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [lsu_pkg::xlen-1:0]  req_addr,
    input  logic [lsu_pkg::xlen-1:0]  req_wdata,
    input  logic [lsu_pkg::mask_w-1:0] req_mask,
    input  logic                      rd_capture,
    output logic [lsu_pkg::xlen-1:0]  rdata,
    axi_lite_if.master                bus
);

    logic [1:0] byte_off;
    logic [4:0] bit_off;

    assign byte_off = req_addr[1:0];
    assign bit_off = {byte_off, 3'b000};

    // requester holds its payload until finish, so the shifted
    // values stay stable for the whole write
    assign bus.wdata = req_wdata << bit_off;

    // lanes pushed past byte 3 fall off the top
    assign bus.wstrb = req_mask << byte_off;

    // right shift zero-fills the upper lanes
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (rd_capture) begin
            rdata <= bus.rdata >> bit_off;
        end
    end

endmodule

//--- verilog/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_rd,
    input  logic                     req_wr,
    input  logic [lsu_pkg::xlen-1:0] req_addr,
    output logic                     rd_capture,
    output logic                     finish,
    axi_lite_if.master               bus
);

    lsu_pkg::lsu_state_e state;

    // per-channel completion within one write
    logic aw_done;
    logic w_done;

    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic aw_ok;
    logic w_ok;

    assign ar_hs = bus.arvalid && bus.arready;
    assign r_hs = bus.rvalid && bus.rready;
    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs = bus.wvalid && bus.wready;
    assign b_hs = bus.bvalid && bus.bready;

    // done earlier or finishing this cycle
    assign aw_ok = aw_done || aw_hs;
    assign w_ok = w_done || w_hs;

    // word-aligned, request address is held until finish
    assign bus.araddr = {req_addr[lsu_pkg::xlen-1:2], 2'b00};
    assign bus.awaddr = {req_addr[lsu_pkg::xlen-1:2], 2'b00};

    assign rd_capture = r_hs;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::ls_idle;
            bus.arvalid <= 1'b0;
            bus.rready <= 1'b0;
            bus.awvalid <= 1'b0;
            bus.wvalid <= 1'b0;
            bus.bready <= 1'b0;
            aw_done <= 1'b0;
            w_done <= 1'b0;
        end else begin
            case (state)
                lsu_pkg::ls_idle: begin
                    if (req_rd) begin
                        bus.arvalid <= 1'b1;
                        state <= lsu_pkg::ls_rd_addr;
                    end else if (req_wr) begin
                        bus.awvalid <= 1'b1;
                        bus.wvalid <= 1'b1;
                        aw_done <= 1'b0;
                        w_done <= 1'b0;
                        state <= lsu_pkg::ls_wr_req;
                    end
                end
                lsu_pkg::ls_rd_addr: begin
                    if (ar_hs) begin
                        bus.arvalid <= 1'b0;
                        bus.rready <= 1'b1;
                        state <= lsu_pkg::ls_rd_data;
                    end
                end
                lsu_pkg::ls_rd_data: begin
                    if (r_hs) begin
                        bus.rready <= 1'b0;
                        state <= lsu_pkg::ls_idle;
                    end
                end
                lsu_pkg::ls_wr_req: begin
                    // aw and w may complete in different cycles
                    if (aw_hs) begin
                        bus.awvalid <= 1'b0;
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        bus.wvalid <= 1'b0;
                        w_done <= 1'b1;
                    end
                    if (aw_ok && w_ok) begin
                        bus.bready <= 1'b1;
                        state <= lsu_pkg::ls_wr_resp;
                    end
                end
                lsu_pkg::ls_wr_resp: begin
                    if (b_hs) begin
                        bus.bready <= 1'b0;
                        state <= lsu_pkg::ls_idle;
                    end
                end
                default: begin
                    state <= lsu_pkg::ls_idle;
                end
            endcase
        end
    end

    // one cycle after the last handshake of the access
    always_ff @(posedge clk) begin
        if (rst) begin
            finish <= 1'b0;
        end else begin
            finish <= r_hs || b_hs;
        end
    end

    a_req_only_idle: assert property (@(posedge clk) disable iff (rst)
        (req_rd || req_wr) |-> (state == lsu_pkg::ls_idle));

    a_req_one_hot: assert property (@(posedge clk) disable iff (rst)
        !(req_rd && req_wr));

    // slave must not see the read address vanish before accepting it
    a_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (bus.arvalid && !bus.arready) |=> bus.arvalid);

endmodule

//--- verilog/mem_delay_timer.sv
`timescale 1ns/1ps

module mem_delay_timer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [lsu_pkg::delay_w-1:0] load_value,
    output logic                        done
);

    logic [lsu_pkg::delay_w-1:0] count;

    // sits at zero once expired, so a slow master sees done held
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign done = (count == '0) && !start;

    // slave only restarts after the previous wait has run out
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start |-> (count == '0));

endmodule

//--- verilog/axi_sram.sv
`timescale 1ns/1ps

module axi_sram (
    input  logic      clk,
    input  logic      rst,
    output logic      timer_start,
    input  logic      timer_done,
    axi_lite_if.slave bus
);

    lsu_pkg::mem_state_e state;

    logic [lsu_pkg::xlen-1:0]   mem [lsu_pkg::mem_words];
    logic [lsu_pkg::mem_aw-1:0] addr_q;
    logic [lsu_pkg::mem_aw-1:0] wr_idx;

    logic ar_hs;
    logic aw_hs;
    logic w_hs;

    // address accepted only from idle; w may trail aw by a state
    assign bus.arready = (state == lsu_pkg::ms_idle);
    assign bus.awready = (state == lsu_pkg::ms_idle);
    assign bus.wready = ((state == lsu_pkg::ms_idle) && bus.awvalid)
                     || (state == lsu_pkg::ms_wr_data);

    assign bus.rvalid = (state == lsu_pkg::ms_rd_resp);
    assign bus.bvalid = (state == lsu_pkg::ms_wr_resp);

    assign ar_hs = bus.arvalid && bus.arready;
    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs = bus.wvalid && bus.wready;

    // latency counts from address accept, or from w on writes
    assign timer_start = ar_hs || w_hs;

    assign wr_idx = (state == lsu_pkg::ms_idle) ? bus.awaddr[lsu_pkg::mem_aw+1:2] : addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::ms_idle;
        end else begin
            case (state)
                lsu_pkg::ms_idle: begin
                    if (ar_hs) begin
                        state <= lsu_pkg::ms_rd_wait;
                    end else if (aw_hs && w_hs) begin
                        state <= lsu_pkg::ms_wr_wait;
                    end else if (aw_hs) begin
                        state <= lsu_pkg::ms_wr_data;
                    end
                end
                lsu_pkg::ms_wr_data: begin
                    if (w_hs) begin
                        state <= lsu_pkg::ms_wr_wait;
                    end
                end
                lsu_pkg::ms_rd_wait: begin
                    if (timer_done) begin
                        state <= lsu_pkg::ms_rd_resp;
                    end
                end
                lsu_pkg::ms_rd_resp: begin
                    if (bus.rready) begin
                        state <= lsu_pkg::ms_idle;
                    end
                end
                lsu_pkg::ms_wr_wait: begin
                    if (timer_done) begin
                        state <= lsu_pkg::ms_wr_resp;
                    end
                end
                lsu_pkg::ms_wr_resp: begin
                    if (bus.bready) begin
                        state <= lsu_pkg::ms_idle;
                    end
                end
                default: begin
                    state <= lsu_pkg::ms_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= bus.araddr[lsu_pkg::mem_aw+1:2];
        end else if (aw_hs) begin
            addr_q <= bus.awaddr[lsu_pkg::mem_aw+1:2];
        end
    end

    // strobed write lands on the w handshake
    always_ff @(posedge clk) begin
        if (w_hs) begin
            for (int i = 0; i < lsu_pkg::mask_w; i++) begin
                if (bus.wstrb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    // word fetched as the wait ends, ready for rvalid next cycle
    always_ff @(posedge clk) begin
        if ((state == lsu_pkg::ms_rd_wait) && timer_done) begin
            bus.rdata <= mem[addr_q];
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (bus.rvalid && !bus.rready) |=> bus.rvalid);

endmodule

//--- verilog/lsu_subsys.sv
`timescale 1ns/1ps

module lsu_subsys (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_rd,
    input  logic                        req_wr,
    input  logic [lsu_pkg::xlen-1:0]    req_addr,
    input  logic [lsu_pkg::xlen-1:0]    req_wdata,
    input  logic [lsu_pkg::mask_w-1:0]  req_mask,
    input  logic [lsu_pkg::delay_w-1:0] mem_delay,
    output logic [lsu_pkg::xlen-1:0]    rdata,
    output logic                        finish
);

    logic rd_capture;
    logic timer_start;
    logic timer_done;

    axi_lite_if bus0 ();

    lsu_ctrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .req_rd     (req_rd),
        .req_wr     (req_wr),
        .req_addr   (req_addr),
        .rd_capture (rd_capture),
        .finish     (finish),
        .bus        (bus0.master)
    );

    lsu_align align0 (
        .clk        (clk),
        .rst        (rst),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_mask   (req_mask),
        .rd_capture (rd_capture),
        .rdata      (rdata),
        .bus        (bus0.master)
    );

    axi_sram sram0 (
        .clk         (clk),
        .rst         (rst),
        .timer_start (timer_start),
        .timer_done  (timer_done),
        .bus         (bus0.slave)
    );

    mem_delay_timer timer0 (
        .clk        (clk),
        .rst        (rst),
        .start      (timer_start),
        .load_value (mem_delay),
        .done       (timer_done)
    );

endmodule

//--- tb/lsu_subsys_tb.sv
`timescale 1ns/1ps

module lsu_subsys_tb;

    logic        clk;
    logic        rst;
    logic        req_rd;
    logic        req_wr;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_mask;
    logic [2:0]  mem_delay;
    logic [31:0] rdata;
    logic        finish;

    logic [31:0] ref_mem [256];
    logic [31:0] rng_state;
    logic [31:0] exp_rdata;
    logic [31:0] last_rdata;
    logic [31:0] r;
    logic [31:0] d0;
    bit          chk_rd;
    int          errors;
    int          test_err_base;
    int          n_pass;
    int          n_fail;
    int          n_access;
    int          n_finish;
    int          lat;
    int          lat0;

    lsu_subsys dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_rd    (req_rd),
        .req_wr    (req_wr),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_mask  (req_mask),
        .mem_delay (mem_delay),
        .rdata     (rdata),
        .finish    (finish)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // writes update the model and return zero, reads return the expected rdata
    function automatic logic [31:0] model_access(input bit wr, input logic [31:0] addr,
                                                 input logic [31:0] data, input logic [3:0] mask);
        logic [7:0]  idx;
        logic [1:0]  off;
        logic [31:0] lane_data;
        logic [3:0]  lane_mask;
        int          i;
        idx = addr[9:2];
        off = addr[1:0];
        lane_data = data << (8 * off);
        lane_mask = mask << off;
        if (wr) begin
            for (i = 0; i < 4; i++) begin
                if (lane_mask[i]) begin
                    ref_mem[idx][8*i +: 8] = lane_data[8*i +: 8];
                end
            end
            return 32'h0;
        end
        return ref_mem[idx] >> (8 * off);
    endfunction

    // one-cycle strobe, then count cycles until finish
    task automatic run_access(input bit wr, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
        bit seen;
        @(negedge clk);
        req_addr = addr;
        req_wdata = data;
        req_mask = mask;
        chk_rd = !wr;
        exp_rdata = model_access(wr, addr, data, mask);
        req_rd = !wr;
        req_wr = wr;
        n_access++;
        lat = 0;
        seen = 0;
        while (!seen && lat < 200) begin
            @(negedge clk);
            req_rd = 1'b0;
            req_wr = 1'b0;
            lat++;
            if (finish) begin
                seen = 1;
                last_rdata = rdata;
            end
        end
        if (!seen) begin
            $display("access to address %h got no finish within 200 cycles", addr);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) @(negedge clk);
        assert (n_finish == n_access) else begin
            $display("ERR t=%0t finish_count got %0d exp %0d", $time, n_finish, n_access);
            errors++;
        end
        if (errors == test_err_base) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - test_err_base);
        end
        test_err_base = errors;
        n_access = 0;
        n_finish = 0;
    endtask

    // rdata and finish are settled at the falling edge
    always @(negedge clk) begin
        if (!rst && finish) begin
            n_finish++;
            if (chk_rd) begin
                assert (rdata == exp_rdata) else begin
                    $display("ERR t=%0t rdata got %h exp %h", $time, rdata, exp_rdata);
                    errors++;
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_rd = 1'b0;
        req_wr = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_mask = '0;
        mem_delay = 3'd2;
        rng_state = 32'd31683;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (10) begin
            @(negedge clk);
            assert (!finish && rdata == 32'h0) else begin
                $display("ERR t=%0t finish/rdata got %b/%h exp 0/0", $time, finish, rdata);
                errors++;
            end
        end
        end_test("idle after reset");

        // words 0 to 15 get known contents for everything below
        for (int w = 0; w < 16; w++) begin
            run_access(1, w * 4, xorshift32(), 4'hf);
            run_access(0, w * 4, 32'h0, 4'h0);
        end
        end_test("full word write/read");

        for (int off = 0; off < 4; off++) begin
            run_access(1, 32'h14 + off, xorshift32(), 4'b0001);
            run_access(0, 32'h14, 32'h0, 4'h0);
            run_access(1, 32'h18 + off, xorshift32(), 4'b0011);
            run_access(0, 32'h18, 32'h0, 4'h0);
        end
        end_test("byte and halfword writes");

        for (int off = 1; off < 4; off++) begin
            run_access(0, 32'h0c + off, 32'h0, 4'h0);
        end
        end_test("misaligned reads");

        for (int n = 0; n < 200; n++) begin
            r = xorshift32();
            mem_delay = r[13:11];
            run_access(r[0], {26'h0, r[4:1], r[6:5]}, xorshift32(), r[10:7]);
        end
        end_test("random operations");

        mem_delay = 3'd0;
        run_access(1, 32'h24, 32'hc0de_5a17, 4'hf);
        run_access(0, 32'h24, 32'h0, 4'h0);
        lat0 = lat;
        d0 = last_rdata;
        // cleared so the second write has to land
        run_access(1, 32'h24, 32'h0, 4'hf);
        mem_delay = 3'd7;
        run_access(1, 32'h24, 32'hc0de_5a17, 4'hf);
        run_access(0, 32'h24, 32'h0, 4'h0);
        assert (d0 == exp_rdata && last_rdata == exp_rdata) else begin
            $display("ERR t=%0t rdata_delay0/rdata_delay7 got %h/%h exp %h",
                     $time, d0, last_rdata, exp_rdata);
            errors++;
        end
        // seven extra wait cycles in the slave
        assert (lat == lat0 + 7) else begin
            $display("ERR t=%0t read_latency got %0d exp %0d", $time, lat, lat0 + 7);
            errors++;
        end
        end_test("delay 0 versus delay 7");

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- lsu_subsys.f
verilog/lsu_pkg.sv
verilog/axi_lite_if.sv
verilog/lsu_align.sv
verilog/lsu_ctrl.sv
verilog/mem_delay_timer.sv
verilog/axi_sram.sv
verilog/lsu_subsys.sv
tb/lsu_subsys_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = lsu_subsys_tb
FLIST = lsu_subsys.f
BUILD = obj_dir
LOG   = sim.log
PASS  = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
